//--- logic/coreSettings.svh
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// Datapath and address width
`define CORE_WORD_WIDTH 32

// General registers, r0 hardwired to zero
`define CORE_REG_COUNT 32

// First fetch address after reset
`define CORE_RESET_PC 32'h0000_0000

`endif

//--- logic/corePkg.sv
`include "coreSettings.svh"

package corePkg;

    typedef logic [`CORE_WORD_WIDTH-1:0] word_t;
    typedef logic [$clog2(`CORE_REG_COUNT)-1:0] regAddr_t;

    // Primary opcodes kept from MIPS-32
    typedef enum logic [5:0] {
        opSpecial = 6'h00,
        opJ       = 6'h02,
        opBeq     = 6'h04,
        opBne     = 6'h05,
        opAddiu   = 6'h09,
        opAndi    = 6'h0c,
        opOri     = 6'h0d,
        opLui     = 6'h0f,
        opLw      = 6'h23,
        opSw      = 6'h2b
    } opcode_t;

    typedef enum logic [5:0] {
        functSll  = 6'h00,
        functAddu = 6'h21,
        functSubu = 6'h23,
        functAnd  = 6'h24,
        functOr   = 6'h25,
        functXor  = 6'h26,
        functSlt  = 6'h2a
    } funct_t;

    typedef enum logic [3:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluXor,
        aluSlt,
        aluSll,
        aluLui
    } aluOp_t;

    typedef enum logic [1:0] {
        fwdFromReg = 2'd0,
        fwdFromMem = 2'd1,
        fwdFromWb  = 2'd2
    } fwdSel_t;

    // Operand mux shared by decode and execute forwarding
    function automatic word_t selectOperand(fwdSel_t sel, word_t regVal, word_t memVal,
                                            word_t wbVal);
        case (sel)
            fwdFromMem: return memVal;
            fwdFromWb:  return wbVal;
            default:    return regVal;
        endcase
    endfunction

endpackage

//--- logic/fetchStage.sv
`include "coreSettings.svh"

module fetchStage (
    input  logic           clk,
    input  logic           arstN,
    input  logic           stall,
    input  logic           branchTaken,
    input  corePkg::word_t branchTarget,
    input  corePkg::word_t instr,
    output corePkg::word_t instrAddr,
    output corePkg::word_t decInstr,
    output corePkg::word_t decPcPlus4
);
    import corePkg::*;

    word_t pc;
    word_t pcPlus4;
    word_t nextPc;

    assign pcPlus4   = pc + word_t'(4);
    // Redirect lands after the delay slot already being fetched
    assign nextPc    = branchTaken ? branchTarget : pcPlus4;
    assign instrAddr = pc;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pc <= `CORE_RESET_PC;
        end else if (!stall) begin
            pc <= nextPc;
        end
    end

    // IF/ID, instruction clears to a nop
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            decInstr <= '0;
        end else if (!stall) begin
            decInstr <= instr;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            decPcPlus4 <= pcPlus4;
        end
    end

endmodule

//--- logic/decodeStage.sv
`include "coreSettings.svh"

module decodeStage (
    input  logic              clk,
    input  logic              arstN,
    input  logic              bubble,
    input  corePkg::word_t    decInstr,
    input  corePkg::word_t    decPcPlus4,
    input  corePkg::fwdSel_t  fwdDecA,
    input  corePkg::fwdSel_t  fwdDecB,
    input  corePkg::word_t    memResult,
    input  corePkg::word_t    wbData,
    input  corePkg::regAddr_t wbRegAddr,
    input  logic              wbRegWrite,
    output corePkg::regAddr_t decRs,
    output corePkg::regAddr_t decRt,
    output logic              isBranch,
    output logic              branchTaken,
    output corePkg::word_t    branchTarget,
    output corePkg::regAddr_t exRs,
    output corePkg::regAddr_t exRt,
    output corePkg::regAddr_t exRd,
    output corePkg::word_t    exOpA,
    output corePkg::word_t    exOpB,
    output corePkg::word_t    exImm,
    output logic [4:0]        exShamt,
    output corePkg::aluOp_t   exAluOp,
    output logic              exUseImm,
    output logic              exRegDst,
    output logic              exRegWrite,
    output logic              exMemRead,
    output logic              exMemWrite
);
    import corePkg::*;

    opcode_t     opcode;
    funct_t      funct;
    regAddr_t    rd;
    regAddr_t    dest;
    logic [15:0] imm16;
    word_t       regFile [`CORE_REG_COUNT];
    word_t       rfA;
    word_t       rfB;
    word_t       opA;
    word_t       opB;
    word_t       immExt;
    word_t       immSext;
    aluOp_t      aluOp;
    logic        useImm;
    logic        regDst;
    logic        regWrite;
    logic        memRead;
    logic        memWrite;
    logic        zeroExt;
    logic        isBne;
    logic        isJump;

    assign opcode = opcode_t'(decInstr[31:26]);
    assign funct  = funct_t'(decInstr[5:0]);
    assign decRs  = decInstr[25:21];
    assign decRt  = decInstr[20:16];
    assign rd     = decInstr[15:11];
    assign imm16  = decInstr[15:0];

    always_comb begin
        aluOp    = aluAdd;
        useImm   = 1'b0;
        regDst   = 1'b0;
        regWrite = 1'b0;
        memRead  = 1'b0;
        memWrite = 1'b0;
        zeroExt  = 1'b0;
        isBranch = 1'b0;
        isBne    = 1'b0;
        isJump   = 1'b0;
        case (opcode)
            opSpecial: begin
                regDst   = 1'b1;
                regWrite = 1'b1;
                case (funct)
                    functSll:  aluOp = aluSll;
                    functAddu: aluOp = aluAdd;
                    functSubu: aluOp = aluSub;
                    functAnd:  aluOp = aluAnd;
                    functOr:   aluOp = aluOr;
                    functXor:  aluOp = aluXor;
                    functSlt:  aluOp = aluSlt;
                    default:   regWrite = 1'b0;
                endcase
            end
            opAddiu: begin
                useImm   = 1'b1;
                regWrite = 1'b1;
            end
            opAndi, opOri, opLui: begin
                aluOp    = (opcode == opAndi) ? aluAnd : (opcode == opOri) ? aluOr : aluLui;
                useImm   = 1'b1;
                zeroExt  = 1'b1;
                regWrite = 1'b1;
            end
            opLw: begin
                useImm   = 1'b1;
                memRead  = 1'b1;
                regWrite = 1'b1;
            end
            opSw: begin
                useImm   = 1'b1;
                memWrite = 1'b1;
            end
            opBeq: isBranch = 1'b1;
            opBne: begin
                isBranch = 1'b1;
                isBne    = 1'b1;
            end
            opJ: isJump = 1'b1;
            default: ;
        endcase
    end

    // Write in first half as seen by reads
    assign rfA = (decRs == '0) ? '0 :
                 (wbRegWrite && wbRegAddr == decRs) ? wbData : regFile[decRs];
    assign rfB = (decRt == '0) ? '0 :
                 (wbRegWrite && wbRegAddr == decRt) ? wbData : regFile[decRt];

    always_ff @(posedge clk) begin
        if (wbRegWrite && wbRegAddr != '0) begin
            regFile[wbRegAddr] <= wbData;
        end
    end

    assign opA = selectOperand(fwdDecA, rfA, memResult, wbData);
    assign opB = selectOperand(fwdDecB, rfB, memResult, wbData);

    assign immSext = {{16{imm16[15]}}, imm16};
    assign immExt  = zeroExt ? {16'h0000, imm16} : immSext;

    // Branch resolves here; delay slot follows regardless
    assign branchTaken  = isJump | (isBranch & ((opA == opB) ^ isBne));
    assign branchTarget = isJump ? {decPcPlus4[31:28], decInstr[25:0], 2'b00}
                                 : decPcPlus4 + (immSext << 2);

    // Writes to r0 are dropped at decode
    assign dest = regDst ? rd : decRt;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            exRegWrite <= 1'b0;
            exMemRead  <= 1'b0;
            exMemWrite <= 1'b0;
        end else if (bubble) begin
            exRegWrite <= 1'b0;
            exMemRead  <= 1'b0;
            exMemWrite <= 1'b0;
        end else begin
            exRegWrite <= regWrite && (dest != '0);
            exMemRead  <= memRead;
            exMemWrite <= memWrite;
        end
    end

    always_ff @(posedge clk) begin
        exRs     <= decRs;
        exRt     <= decRt;
        exRd     <= rd;
        exOpA    <= opA;
        exOpB    <= opB;
        exImm    <= immExt;
        exShamt  <= decInstr[10:6];
        exAluOp  <= aluOp;
        exUseImm <= useImm;
        exRegDst <= regDst;
    end

endmodule

//--- logic/executeStage.sv
module executeStage (
    input  logic              clk,
    input  logic              arstN,
    input  corePkg::regAddr_t exRt,
    input  corePkg::regAddr_t exRd,
    input  corePkg::word_t    exOpA,
    input  corePkg::word_t    exOpB,
    input  corePkg::word_t    exImm,
    input  logic [4:0]        exShamt,
    input  corePkg::aluOp_t   exAluOp,
    input  logic              exUseImm,
    input  logic              exRegDst,
    input  logic              exRegWrite,
    input  logic              exMemRead,
    input  logic              exMemWrite,
    input  corePkg::fwdSel_t  fwdExA,
    input  corePkg::fwdSel_t  fwdExB,
    input  corePkg::word_t    memResult,
    input  corePkg::word_t    wbData,
    output corePkg::word_t    memAluResult,
    output corePkg::word_t    memStoreData,
    output corePkg::regAddr_t memRegAddr,
    output logic              memRegWrite,
    output logic              memMemRead,
    output logic              memMemWrite,
    output corePkg::regAddr_t exDest
);
    import corePkg::*;

    word_t opA;
    word_t opB;
    word_t aluA;
    word_t aluB;
    word_t aluResult;

    assign opA = selectOperand(fwdExA, exOpA, memResult, wbData);
    assign opB = selectOperand(fwdExB, exOpB, memResult, wbData);

    // sll takes its amount on the A side
    assign aluA = (exAluOp == aluSll) ? word_t'(exShamt) : opA;
    assign aluB = exUseImm ? exImm : opB;

    always_comb begin
        case (exAluOp)
            aluAdd:  aluResult = aluA + aluB;
            aluSub:  aluResult = aluA - aluB;
            aluAnd:  aluResult = aluA & aluB;
            aluOr:   aluResult = aluA | aluB;
            aluXor:  aluResult = aluA ^ aluB;
            aluSlt:  aluResult = word_t'($signed(aluA) < $signed(aluB));
            aluSll:  aluResult = aluB << aluA[4:0];
            aluLui:  aluResult = {aluB[15:0], 16'h0000};
            default: aluResult = aluA + aluB;
        endcase
    end

    assign exDest = exRegDst ? exRd : exRt;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            memRegWrite <= 1'b0;
            memMemRead  <= 1'b0;
            memMemWrite <= 1'b0;
        end else begin
            memRegWrite <= exRegWrite;
            memMemRead  <= exMemRead;
            memMemWrite <= exMemWrite;
        end
    end

    // Store data is rt after forwarding
    always_ff @(posedge clk) begin
        memAluResult <= aluResult;
        memStoreData <= opB;
        memRegAddr   <= exDest;
    end

endmodule

//--- logic/memAccess.sv
module memAccess (
    input  logic              clk,
    input  logic              arstN,
    input  corePkg::word_t    memAluResult,
    input  corePkg::word_t    memStoreData,
    input  corePkg::regAddr_t memRegAddr,
    input  logic              memRegWrite,
    input  logic              memMemRead,
    input  logic              memMemWrite,
    input  corePkg::word_t    dataRdata,
    output corePkg::word_t    dataAddr,
    output corePkg::word_t    dataWdata,
    output logic              dataWe,
    output corePkg::word_t    memResult,
    output corePkg::word_t    wbData,
    output corePkg::regAddr_t wbRegAddr,
    output logic              wbRegWrite
);

    // Word accesses only
    assign dataAddr  = memAluResult;
    assign dataWdata = memStoreData;
    assign dataWe    = memMemWrite;

    // Loads are never forwarded from here
    assign memResult = memAluResult;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            wbRegWrite <= 1'b0;
        end else begin
            wbRegWrite <= memRegWrite;
        end
    end

    always_ff @(posedge clk) begin
        wbData    <= memMemRead ? dataRdata : memAluResult;
        wbRegAddr <= memRegAddr;
    end

endmodule

//--- logic/hazardUnit.sv
module hazardUnit (
    input  corePkg::regAddr_t decRs,
    input  corePkg::regAddr_t decRt,
    input  corePkg::regAddr_t exRs,
    input  corePkg::regAddr_t exRt,
    input  corePkg::regAddr_t exDest,
    input  corePkg::regAddr_t memRegAddr,
    input  corePkg::regAddr_t wbRegAddr,
    input  logic              isBranch,
    input  logic              exRegWrite,
    input  logic              exMemRead,
    input  logic              memRegWrite,
    input  logic              memMemRead,
    input  logic              wbRegWrite,
    output corePkg::fwdSel_t  fwdDecA,
    output corePkg::fwdSel_t  fwdDecB,
    output corePkg::fwdSel_t  fwdExA,
    output corePkg::fwdSel_t  fwdExB,
    output logic              stall,
    output logic              bubble
);
    import corePkg::*;

    logic memFwdOk;
    logic exHitsDec;
    logic memHitsDec;
    logic loadUse;
    logic branchOnEx;
    logic branchOnMemLoad;

    // Memory wins over writeback, r0 never forwarded
    function automatic fwdSel_t pickSource(regAddr_t src, regAddr_t memAddr, logic memOk,
                                           regAddr_t wbAddr, logic wbOk);
        if (src == '0) begin
            return fwdFromReg;
        end else if (memOk && memAddr == src) begin
            return fwdFromMem;
        end else if (wbOk && wbAddr == src) begin
            return fwdFromWb;
        end
        return fwdFromReg;
    endfunction

    // Load data only exists after memory
    assign memFwdOk = memRegWrite && !memMemRead;

    assign fwdDecA = pickSource(decRs, memRegAddr, memFwdOk, wbRegAddr, wbRegWrite);
    assign fwdDecB = pickSource(decRt, memRegAddr, memFwdOk, wbRegAddr, wbRegWrite);
    assign fwdExA  = pickSource(exRs, memRegAddr, memFwdOk, wbRegAddr, wbRegWrite);
    assign fwdExB  = pickSource(exRt, memRegAddr, memFwdOk, wbRegAddr, wbRegWrite);

    assign exHitsDec  = exRegWrite && exDest != '0 && (exDest == decRs || exDest == decRt);
    assign memHitsDec = memRegWrite && memRegAddr != '0 &&
                        (memRegAddr == decRs || memRegAddr == decRt);

    assign loadUse         = exMemRead && exHitsDec;
    // Branch compares in decode, so it waits for the producer to reach memory
    assign branchOnEx      = isBranch && exHitsDec;
    assign branchOnMemLoad = isBranch && memMemRead && memHitsDec;

    assign stall  = loadUse | branchOnEx | branchOnMemLoad;
    assign bubble = loadUse | branchOnEx | branchOnMemLoad;

endmodule

//--- logic/core.sv
module core (
    input  logic           clk,
    input  logic           arstN,
    input  corePkg::word_t instr,
    input  corePkg::word_t dataRdata,
    output corePkg::word_t instrAddr,
    output corePkg::word_t dataAddr,
    output corePkg::word_t dataWdata,
    output logic           dataWe
);
    import corePkg::*;

    // Fetch to decode
    word_t    decInstr;
    word_t    decPcPlus4;
    logic     branchTaken;
    word_t    branchTarget;

    // Decode to execute
    regAddr_t decRs;
    regAddr_t decRt;
    logic     isBranch;
    regAddr_t exRs;
    regAddr_t exRt;
    regAddr_t exRd;
    word_t    exOpA;
    word_t    exOpB;
    word_t    exImm;
    logic [4:0] exShamt;
    aluOp_t   exAluOp;
    logic     exUseImm;
    logic     exRegDst;
    logic     exRegWrite;
    logic     exMemRead;
    logic     exMemWrite;
    regAddr_t exDest;

    // Execute to memory and writeback
    word_t    memAluResult;
    word_t    memStoreData;
    regAddr_t memRegAddr;
    logic     memRegWrite;
    logic     memMemRead;
    logic     memMemWrite;
    word_t    memResult;
    word_t    wbData;
    regAddr_t wbRegAddr;
    logic     wbRegWrite;

    // Hazard control
    fwdSel_t  fwdDecA;
    fwdSel_t  fwdDecB;
    fwdSel_t  fwdExA;
    fwdSel_t  fwdExB;
    logic     stall;
    logic     bubble;

    fetchStage    fetch (.*);
    decodeStage   decode (.*);
    executeStage  execute (.*);
    memAccess     mem (.*);
    hazardUnit    hazard (.*);

endmodule

//--- tb/refModel.svh
`ifndef REF_MODEL_SVH
`define REF_MODEL_SVH

function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
endfunction

function automatic word_t encR(funct_t f, regAddr_t rd, regAddr_t rs, regAddr_t rt,
                               logic [4:0] sh);
    return {6'h00, rs, rt, rd, sh, f};
endfunction

function automatic word_t encI(opcode_t op, regAddr_t rt, regAddr_t rs, logic [15:0] imm);
    return {op, rs, rt, imm};
endfunction

function automatic word_t encJ(word_t target);
    return {opJ, target[27:2]};
endfunction

// Architectural run of one program, delay slots included
function automatic void runModel(input int p);
    word_t    regs [32];
    word_t    pc;
    word_t    npc;
    word_t    nnpc;
    word_t    ins;
    word_t    a;
    word_t    b;
    word_t    res;
    word_t    sext;
    word_t    addr;
    regAddr_t dst;
    logic     wr;
    for (int i = 0; i < 32; i++) begin
        regs[i] = '0;
    end
    for (int i = 0; i < 64; i++) begin
        modelMem[i] = fillWord(i);
    end
    pc  = `CORE_RESET_PC;
    npc = pc + 32'd4;
    for (int step = 0; step < 2000; step++) begin
        ins = progMem[p][pc[9:2]];
        // j to itself ends the program
        if (ins[31:26] == opJ && {pc[31:28], ins[25:0], 2'b00} == pc) begin
            break;
        end
        a    = regs[ins[25:21]];
        b    = regs[ins[20:16]];
        sext = {{16{ins[15]}}, ins[15:0]};
        addr = a + sext;
        nnpc = npc + 32'd4;
        wr   = 1'b1;
        dst  = ins[20:16];
        res  = '0;
        case (opcode_t'(ins[31:26]))
            opSpecial: begin
                dst = ins[15:11];
                case (funct_t'(ins[5:0]))
                    functAddu: res = a + b;
                    functSubu: res = a - b;
                    functAnd:  res = a & b;
                    functOr:   res = a | b;
                    functXor:  res = a ^ b;
                    functSlt:  res = {31'd0, $signed(a) < $signed(b)};
                    functSll:  res = b << ins[10:6];
                    default:   wr = 1'b0;
                endcase
            end
            opAddiu: res = a + sext;
            opAndi:  res = a & {16'h0000, ins[15:0]};
            opOri:   res = a | {16'h0000, ins[15:0]};
            opLui:   res = {ins[15:0], 16'h0000};
            opLw:    res = modelMem[addr[7:2]];
            opSw: begin
                wr = 1'b0;
                modelMem[addr[7:2]] = b;
                expAddr.push_back(addr);
                expData.push_back(b);
            end
            opBeq: begin
                wr = 1'b0;
                if (a == b) nnpc = pc + 32'd4 + (sext << 2);
            end
            opBne: begin
                wr = 1'b0;
                if (a != b) nnpc = pc + 32'd4 + (sext << 2);
            end
            opJ: begin
                wr   = 1'b0;
                nnpc = {npc[31:28], ins[25:0], 2'b00};
            end
            default: wr = 1'b0;
        endcase
        if (wr && dst != '0) begin
            regs[dst] = res;
        end
        pc  = npc;
        npc = nnpc;
    end
endfunction

`endif

//--- tb/coreTb.sv
`include "coreSettings.svh"

module coreTb;
    import corePkg::*;

    localparam int NUM_PROGS = 6;
    localparam int PROG_MAX  = 256;
    localparam int QUIET     = 8;

    logic  clk;
    logic  arstN;
    word_t instr;
    word_t dataRdata;
    word_t instrAddr;
    word_t dataAddr;
    word_t dataWdata;
    logic  dataWe;

    word_t       imem [PROG_MAX];
    word_t       dmem [64];
    word_t       modelMem [64];
    word_t       progMem [NUM_PROGS][PROG_MAX];
    int          progLen [NUM_PROGS];
    word_t       expAddr [$];
    word_t       expData [$];
    logic [31:0] rngState;
    int          watchLimit;

    function automatic word_t fillWord(int idx);
        return (word_t'(idx) * 32'h9e37_79b1) ^ 32'hc3a5_0f1e;
    endfunction

    `include "refModel.svh"

    core uut (.*);

    assign instr     = imem[instrAddr[9:2]];
    assign dataRdata = dmem[dataAddr[7:2]];

    always @(posedge clk) begin
        if (arstN && dataWe) begin
            dmem[dataAddr[7:2]] <= dataWdata;
        end
    end

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic reportFailure();
        $display("TEST FAILED");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic checkStoreAddr(word_t got, word_t exp);
        if (got !== exp) begin
            $display("[ERROR] %0t: store address %h, expected %h", $time, got, exp);
            reportFailure();
        end
    endtask

    task automatic checkStoreData(word_t got, word_t exp);
        if (got !== exp) begin
            $display("[ERROR] %0t: store data %h, expected %h", $time, got, exp);
            reportFailure();
        end
    endtask

    task automatic checkFetchAddr(word_t got, word_t exp);
        if (got !== exp) begin
            $display("[ERROR] %0t: fetch address %h after reset, expected %h", $time, got, exp);
            reportFailure();
        end
    endtask

    // Sample at the falling edge, away from register updates
    always @(negedge clk) begin
        if (arstN && dataWe) begin
            if (expAddr.size() == 0) begin
                $display("[ERROR] %0t: extra store to %h", $time, dataAddr);
                reportFailure();
            end else begin
                checkStoreAddr(dataAddr, expAddr.pop_front());
                checkStoreData(dataWdata, expData.pop_front());
            end
        end
    end

    initial begin
        #1;
        repeat (watchLimit) @(posedge clk);
        $display("Timeout: %0d expected stores never appeared", expAddr.size());
        $display("TEST FAILED");
        $fatal(1, "watchdog expired");
    end

    function automatic logic [31:0] randWord();
        rngState = xorshift(rngState);
        return rngState;
    endfunction

    function automatic regAddr_t randReg();
        logic [31:0] r;
        r = randWord();
        return regAddr_t'(r % 8);
    endfunction

    function automatic regAddr_t randNonZero();
        logic [31:0] r;
        r = randWord();
        return regAddr_t'(1 + r % 7);
    endfunction

    function automatic logic [15:0] randOff();
        logic [31:0] r;
        r = randWord();
        return {8'h00, r[7:2], 2'b00};
    endfunction

    task automatic emit(input int p, input word_t w);
        progMem[p][progLen[p]] = w;
        progLen[p]++;
    endtask

    task automatic aluInstr(input int p, input regAddr_t d, input regAddr_t a, input regAddr_t b);
        logic [31:0] r;
        r = randWord();
        case (r % 11)
            0: emit(p, encR(functAddu, d, a, b, 5'd0));
            1: emit(p, encR(functSubu, d, a, b, 5'd0));
            2: emit(p, encR(functAnd, d, a, b, 5'd0));
            3: emit(p, encR(functOr, d, a, b, 5'd0));
            4: emit(p, encR(functXor, d, a, b, 5'd0));
            5: emit(p, encR(functSlt, d, a, b, 5'd0));
            6: emit(p, encR(functSll, d, '0, b, r[12:8]));
            7: emit(p, encI(opAddiu, d, a, r[31:16]));
            8: emit(p, encI(opAndi, d, a, r[31:16]));
            9: emit(p, encI(opOri, d, a, r[31:16]));
            default: emit(p, encI(opLui, d, '0, r[31:16]));
        endcase
    endtask

    task automatic genProgram(input int p);
        logic [31:0] r;
        regAddr_t    a;
        regAddr_t    b;
        regAddr_t    d;
        int          nSeg;
        progLen[p] = 0;
        // Register file is not reset, so seed every register in use
        for (int i = 1; i < 8; i++) begin
            r = randWord();
            emit(p, encI(opAddiu, regAddr_t'(i), '0, r[15:0]));
        end
        r    = randWord();
        nSeg = 12 + int'(r % 8);
        for (int s = 0; s < nSeg; s++) begin
            r = randWord();
            a = randNonZero();
            b = randNonZero();
            d = randReg();
            case (r % 4)
                0: begin
                    aluInstr(p, a, randReg(), randReg());
                    aluInstr(p, b, a, randReg());
                    aluInstr(p, d, randReg(), b);
                    emit(p, encI(opSw, d, '0, randOff()));
                end
                1: begin
                    // r0 as a destination must read back as zero
                    aluInstr(p, '0, a, b);
                    aluInstr(p, d, '0, a);
                    aluInstr(p, d, d, b);
                    aluInstr(p, a, d, d);
                    emit(p, encI(opSw, a, '0, randOff()));
                end
                2: begin
                    emit(p, encI(opLw, a, '0, randOff()));
                    aluInstr(p, b, a, randReg());
                    emit(p, encI(opSw, b, '0, randOff()));
                end
                default: begin
                    emit(p, encI(opLw, a, '0, randOff()));
                    if (r[20]) begin
                        emit(p, encR(functOr, b, a, '0, 5'd0));
                    end else begin
                        aluInstr(p, b, randReg(), randReg());
                    end
                    emit(p, encI(r[21] ? opBeq : opBne, b, a, 16'd2));
                    emit(p, encI(opSw, randReg(), '0, randOff()));
                    emit(p, encI(opSw, randReg(), '0, randOff()));
                    emit(p, encI(opSw, randReg(), '0, randOff()));
                end
            endcase
        end
        emit(p, encJ(word_t'(progLen[p] * 4)));
        emit(p, '0);
    endtask

    task automatic runProgram(input int p);
        @(posedge clk);
        #1 arstN = 1'b0;
        for (int i = 0; i < PROG_MAX; i++) begin
            imem[i] = (i < progLen[p]) ? progMem[p][i] : '0;
        end
        for (int i = 0; i < 64; i++) begin
            dmem[i] = fillWord(i);
        end
        runModel(p);
        repeat (8) @(posedge clk);
        #1 arstN = 1'b1;
        checkFetchAddr(instrAddr, `CORE_RESET_PC);
        while (expAddr.size() != 0) begin
            @(posedge clk);
        end
        // Window for stray stores after the last expected one
        repeat (QUIET) @(posedge clk);
    endtask

    initial begin
        arstN      = 1'b0;
        rngState   = 32'h99b0345e;
        watchLimit = 0;
        for (int i = 0; i < PROG_MAX; i++) begin
            imem[i] = '0;
        end
        for (int i = 0; i < 64; i++) begin
            dmem[i] = fillWord(i);
        end
        for (int p = 0; p < NUM_PROGS; p++) begin
            genProgram(p);
            watchLimit += progLen[p] * 4 + 8 + QUIET + 2;
        end
        for (int p = 0; p < NUM_PROGS; p++) begin
            runProgram(p);
        end
        $display("TEST OK");
        $finish;
    end

endmodule

//--- files.f
+incdir+logic
+incdir+tb
logic/corePkg.sv
logic/fetchStage.sv
logic/decodeStage.sv
logic/executeStage.sv
logic/memAccess.sv
logic/hazardUnit.sv
logic/core.sv
tb/coreTb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing
TOP       = coreTb
FILELIST  = files.f
OBJDIR    = obj_dir
LOG       = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	-./$(OBJDIR)/V$(TOP) | tee $(LOG)
	@grep -q "TEST OK" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
